/* int_pipe.f */
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/int_decode.sv
source/int_execute.sv
source/int_result.sv
source/int_pipe.sv
sim/int_pipe_sva.sv
sim/int_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the int_pipe testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f int_pipe.f --top-module int_pipe_tb \
    -o int_pipe_sim || exit 1
out=$(./obj_dir/int_pipe_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

/* sim/int_pipe_vectors.txt */
// Columns in hex: pc, instruction, expected rd, expected value, expected illegal
// Value is not compared on illegal rows; a pc of ffffffff ends the list
// Fresh registers read as zero, x5 has never been written
00000100 12328093 01 00000123 0
00000104 ffb00113 02 fffffffb 0
00000108 00700193 03 00000007 0
// lui, auipc
0000010c 80000237 04 80000000 0
00000110 12345317 06 12345110 0
// Register forms, sources still in flight at first
00000114 002083b3 07 0000011e 0
00000118 40208433 08 00000128 0
0000011c 003124b3 09 00000001 0
00000120 00313533 0a 00000000 0
00000124 003095b3 0b 00009180 0
00000128 0020c633 0c fffffed8 0
0000012c 003156b3 0d 01ffffff 0
00000130 40315733 0e ffffffff 0
00000134 0030e7b3 0f 00000127 0
00000138 0020f833 10 00000123 0
// Shift amount 0x24 uses only its low 5 bits
0000013c 02400913 12 00000024 0
00000140 012098b3 11 00001230 0
// Immediate forms
00000144 fff12993 13 00000001 0
00000148 fff1ba13 14 00000001 0
0000014c fff0ca93 15 fffffedc 0
00000150 0f00eb13 16 000001f3 0
00000154 0ff17b93 17 000000fb 0
00000158 01f09c13 18 80000000 0
0000015c 00425c93 19 08000000 0
00000160 40425d13 1a f8000000 0
// Back-to-back chain on x27
00000164 001d8d93 1b 00000001 0
00000168 001d8d93 1b 00000002 0
0000016c 001d8d93 1b 00000003 0
00000170 01bd8db3 1b 00000006 0
// Write to x0, then read x0
00000174 00508013 00 00000128 0
00000178 00000e33 1c 00000000 0
// Store and mul are illegal, x7 and x9 keep their values
0000017c 0013a3a3 07 00000000 1
00000180 00038e93 1d 0000011e 0
00000184 022084b3 09 00000000 1
00000188 00048f13 1e 00000001 0
0000018c ffffffb7 1f fffff000 0
ffffffff 00000000 00 00000000 0

/* sim/int_pipe_tb.sv */
// Vector driven testbench for int_pipe
// Vectors come from sim/int_pipe_vectors.txt, ended by a line with pc ffffffff
// out_ready_i is pulled low about one cycle in four by an LFSR

module int_pipe_tb;

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int    MAX_VEC       = 64;
    localparam int    WORDS_PER_VEC = 5;      // pc, instr, rd, value, illegal
    localparam int    ACCEPT_LIMIT  = 200;    // Cycles per input handshake
    localparam int    DRAIN_LIMIT   = 200;
    localparam string VEC_FILE      = "sim/int_pipe_vectors.txt";

    logic        g_clk = 1'b0;
    logic        rst_i;
    logic        in_valid_i;
    logic        in_ready_o;
    instr_req_t  in_req_i;
    logic        out_valid_o;
    logic        out_ready_i = 1'b1;
    exec_res_t   out_res_o;

    logic [31:0] raw_words [0:MAX_VEC*WORDS_PER_VEC-1];
    logic [31:0] vec_instr [0:MAX_VEC-1];
    exec_res_t   exp_res   [0:MAX_VEC-1];
    int          num_vec;
    int          exp_q[$];                    // Indices of accepted vectors
    int          checked_count  = 0;
    int          mismatch_count = 0;
    int          other_count    = 0;
    int          mon_idx;
    exec_res_t   mon_exp;
    logic [31:0] lfsr_state = 32'h13ab;
    logic        bp_bit0;
    logic        bp_bit1;

    int_pipe dut_i (
        .g_clk       (g_clk      ),
        .rst_i       (rst_i      ),
        .in_valid_i  (in_valid_i ),
        .in_ready_o  (in_ready_o ),
        .in_req_i    (in_req_i   ),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_res_o   (out_res_o  )
    );

    always #5 g_clk = ~g_clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Back-pressure
    // ------------------------------------------------------------
    always @(posedge g_clk) begin
        if (rst_i) begin
            out_ready_i <= 1'b1;
        end else begin
            lfsr_state = lfsr_next(lfsr_state);
            bp_bit0    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            bp_bit1    = lfsr_state[0];
            out_ready_i <= !(bp_bit0 && bp_bit1);
        end
    end

    // Output monitor, sampled mid-cycle where everything is settled
    // ------------------------------------------------------------
    always @(negedge g_clk) begin
        if (!rst_i && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: out_valid_o with no instruction outstanding", $time);
                mismatch_count++;
            end else if (out_ready_i) begin
                mon_idx = exp_q.pop_front();
                mon_exp = exp_res[mon_idx];
                checked_count++;
                if (out_res_o.pc !== mon_exp.pc) begin
                    $display("ERROR at %0t: vector %0d pc %h, expected %h",
                             $time, mon_idx, out_res_o.pc, mon_exp.pc);
                    mismatch_count++;
                end
                if (out_res_o.rd !== mon_exp.rd) begin
                    $display("ERROR at %0t: vector %0d rd %0d, expected %0d",
                             $time, mon_idx, out_res_o.rd, mon_exp.rd);
                    mismatch_count++;
                end
                if (out_res_o.illegal !== mon_exp.illegal) begin
                    $display("ERROR at %0t: vector %0d illegal %b, expected %b",
                             $time, mon_idx, out_res_o.illegal, mon_exp.illegal);
                    mismatch_count++;
                end
                if (!mon_exp.illegal && out_res_o.value !== mon_exp.value) begin
                    $display("ERROR at %0t: vector %0d value %h, expected %h",
                             $time, mon_idx, out_res_o.value, mon_exp.value);
                    mismatch_count++;
                end
            end
        end
    end

    task automatic load_vectors();
        logic found;
        int   base;
        found   = 1'b0;
        num_vec = 0;
        $readmemh(VEC_FILE, raw_words);
        for (int i = 0; i < MAX_VEC; i++) begin
            base = i * WORDS_PER_VEC;
            if (!found && raw_words[base] === 32'hffff_ffff) begin
                found = 1'b1;
            end else if (!found) begin
                exp_res[i].pc      = raw_words[base];
                vec_instr[i]       = raw_words[base+1];
                exp_res[i].rd      = raw_words[base+2][4:0];
                exp_res[i].value   = raw_words[base+3];
                exp_res[i].illegal = raw_words[base+4][0];
                num_vec++;
            end
        end
        if (!found) begin
            $display("Vector file %s is missing or has no end marker line", VEC_FILE);
            other_count++;
            num_vec = 0;
        end
    endtask

    // Called right after a rising edge, returns on the edge that took the vector
    task automatic send_vector(input int idx, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        in_valid_i     <= 1'b1;
        in_req_i.pc    <= exp_res[idx].pc;
        in_req_i.instr <= vec_instr[idx];
        while (!ok && waited < ACCEPT_LIMIT) begin
            @(negedge g_clk);
            if (in_ready_o) begin
                ok = 1'b1;
                exp_q.push_back(idx);
            end
            @(posedge g_clk);
            waited++;
        end
        if (!ok) begin
            $display("Timeout: vector %0d not accepted within %0d cycles", idx, ACCEPT_LIMIT);
        end
    endtask

    task automatic wait_drained(output logic ok);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge g_clk);
            waited++;
        end
        ok = (exp_q.size() == 0);
        if (!ok) begin
            $display("Timeout: %0d results still outstanding after the last input",
                     exp_q.size());
        end
    endtask

    task automatic report_and_finish();
        int sva_fails;
        sva_fails = dut_i.u_sva.sva_fail_count;
        $display("Checked %0d of %0d results, mismatches %0d, other failures %0d, assertions %0d",
                 checked_count, num_vec, mismatch_count, other_count, sva_fails);
        if (mismatch_count == 0 && other_count == 0 && sva_fails == 0 && num_vec > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Main flow
    // ------------------------------------------------------------
    initial begin : main_flow
        logic ok;
        int   idx;
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        in_req_i   = '0;
        ok         = 1'b1;
        idx        = 0;
        load_vectors();
        repeat (16) @(posedge g_clk);
        rst_i <= 1'b0;
        while (ok && idx < num_vec) begin
            send_vector(idx, ok);
            idx++;
        end
        in_valid_i <= 1'b0;
        if (ok) begin
            wait_drained(ok);
        end
        if (!ok) begin
            other_count++;
        end
        repeat (2) @(posedge g_clk);
        if (checked_count != num_vec) begin
            $display("Saw %0d results for %0d vectors", checked_count, num_vec);
            other_count++;
        end
        report_and_finish();
    end

endmodule

/* sim/int_pipe_sva.sv */
// Port level checks for int_pipe attached with bind
// Only DUT outputs are checked and input stability is not assumed
// The output hold rule is disabled while rst_i is high

module int_pipe_sva (
    input  logic                 g_clk,
    input  logic                 rst_i,
    input  logic                 in_ready_o,
    input  logic                 out_valid_o,
    input  logic                 out_ready_i,
    input  pipe_pkg::exec_res_t  out_res_o
);

    int sva_fail_count = 0;

    // A stalled output keeps both its valid and its record
    out_hold_a: assert property (@(posedge g_clk) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_res_o)))
        else begin
            sva_fail_count++;
            $error("Output record changed or dropped while out_ready_i was low");
        end

    reset_clears_out_a: assert property (@(posedge g_clk)
        rst_i |=> !out_valid_o)
        else begin
            sva_fail_count++;
            $error("out_valid_o high after a reset cycle");
        end

    // Empty pipe right after reset takes input at once
    ready_after_reset_a: assert property (@(posedge g_clk)
        $fell(rst_i) |-> in_ready_o)
        else begin
            sva_fail_count++;
            $error("in_ready_o low on the first cycle after reset");
        end

endmodule

bind int_pipe int_pipe_sva u_sva (
    .g_clk       (g_clk      ),
    .rst_i       (rst_i      ),
    .in_ready_o  (in_ready_o ),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_res_o   (out_res_o  )
);

/* source/int_pipe.sv */
// Three stage RV32I arithmetic slice: decode, execute, result
// Valid/ready on both ends, in order, at most three instructions in flight
// Minimum latency from input handshake to out_valid_o is 3 cycles

module int_pipe (
    input  logic                  g_clk,
    input  logic                  rst_i,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  pipe_pkg::instr_req_t  in_req_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output pipe_pkg::exec_res_t   out_res_o
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    // Stage links
    // ------------------------------------------------------------
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xword_t     rs1_data;
    xword_t     rs2_data;
    pend_dst_t  ex_pend;
    pend_dst_t  res_pend;
    logic       uop_valid;
    logic       uop_ready;
    uop_t       uop;
    logic       res_valid;
    logic       res_ready;
    exec_res_t  res;

    int_decode u_decode (
        .g_clk       (g_clk      ),
        .rst_i       (rst_i      ),
        .in_valid_i  (in_valid_i ),
        .in_ready_o  (in_ready_o ),
        .in_req_i    (in_req_i   ),
        .rs1_addr_o  (rs1_addr   ),
        .rs2_addr_o  (rs2_addr   ),
        .rs1_data_i  (rs1_data   ),
        .rs2_data_i  (rs2_data   ),
        .ex_pend_i   (ex_pend    ),
        .res_pend_i  (res_pend   ),
        .uop_valid_o (uop_valid  ),
        .uop_ready_i (uop_ready  ),
        .uop_o       (uop        )
    );

    int_execute u_execute (
        .g_clk       (g_clk      ),
        .rst_i       (rst_i      ),
        .uop_valid_i (uop_valid  ),
        .uop_ready_o (uop_ready  ),
        .uop_i       (uop        ),
        .ex_pend_o   (ex_pend    ),
        .res_valid_o (res_valid  ),
        .res_ready_i (res_ready  ),
        .res_o       (res        )
    );

    // Also owns the register file read by decode
    int_result u_result (
        .g_clk       (g_clk      ),
        .rst_i       (rst_i      ),
        .res_valid_i (res_valid  ),
        .res_ready_o (res_ready  ),
        .res_i       (res        ),
        .rs1_addr_i  (rs1_addr   ),
        .rs2_addr_i  (rs2_addr   ),
        .rs1_data_o  (rs1_data   ),
        .rs2_data_o  (rs2_data   ),
        .res_pend_o  (res_pend   ),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_res_o   (out_res_o  )
    );

endmodule

/* source/int_result.sv */
// Retire stage: one result register, the output port and the register file
// Registers are written only on the output handshake, never for illegal
// records or rd of x0; x0 always reads as zero
// Both read ports are combinational

module int_result (
    input  logic                   g_clk,
    input  logic                   rst_i,

    input  logic                   res_valid_i,
    output logic                   res_ready_o,
    input  pipe_pkg::exec_res_t    res_i,

    input  rv_isa_pkg::reg_addr_t  rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t  rs2_addr_i,
    output rv_isa_pkg::xword_t     rs1_data_o,
    output rv_isa_pkg::xword_t     rs2_data_o,

    output pipe_pkg::pend_dst_t    res_pend_o,

    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output pipe_pkg::exec_res_t    out_res_o
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic       out_valid_q;
    exec_res_t  out_q;
    logic       accept;
    logic       retire;
    logic       wr_en;
    xword_t     regs [1:NUM_REGS-1];    // No storage for x0

    // Result register
    // ------------------------------------------------------------
    assign res_ready_o = !out_valid_q || out_ready_i;
    assign accept      = res_valid_i && res_ready_o;
    assign retire      = out_valid_q && out_ready_i;

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (retire) begin
            out_valid_q <= 1'b0;
        end
    end

    // Held stable while the output is back-pressured
    always_ff @(posedge g_clk) begin
        if (accept) begin
            out_q <= res_i;
        end
    end

    assign res_pend_o  = '{valid: out_valid_q, rd: out_q.rd};
    assign out_valid_o = out_valid_q;
    assign out_res_o   = out_q;

    // Register file
    // ------------------------------------------------------------
    assign wr_en = retire && !out_q.illegal && (out_q.rd != '0);

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[out_q.rd] <= out_q.value;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* source/int_execute.sv */
// Single cycle ALU with one output register
// Shift amounts come from the low 5 bits of operand B
// Accepts a new uop whenever its register is empty or being emptied

module int_execute (
    input  logic                  g_clk,
    input  logic                  rst_i,

    input  logic                  uop_valid_i,
    output logic                  uop_ready_o,
    input  pipe_pkg::uop_t        uop_i,

    output pipe_pkg::pend_dst_t   ex_pend_o,

    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output pipe_pkg::exec_res_t   res_o
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    xword_t     alu_a;
    xword_t     alu_b;
    logic [4:0] shamt;
    xword_t     alu_value;
    logic       accept;
    logic       res_valid_q;
    exec_res_t  res_q;

    assign alu_a = uop_i.opr_a;
    assign alu_b = uop_i.opr_b;
    assign shamt = alu_b[4:0];

    // ALU
    // ------------------------------------------------------------
    always_comb begin
        case (uop_i.alu_op)
            ADD:     alu_value = alu_a + alu_b;
            SUB:     alu_value = alu_a - alu_b;
            SLL:     alu_value = alu_a << shamt;
            SLT:     alu_value = xword_t'($signed(alu_a) < $signed(alu_b));
            SLTU:    alu_value = xword_t'(alu_a < alu_b);
            XOR:     alu_value = alu_a ^ alu_b;
            SRL:     alu_value = alu_a >> shamt;
            SRA:     alu_value = xword_t'($signed(alu_a) >>> shamt);
            OR:      alu_value = alu_a | alu_b;
            AND:     alu_value = alu_a & alu_b;
            default: alu_value = '0;
        endcase
    end

    // Execute to result register
    // ------------------------------------------------------------
    assign uop_ready_o = !res_valid_q || res_ready_i;
    assign accept      = uop_valid_i && uop_ready_o;

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            res_q.pc      <= uop_i.pc;
            res_q.rd      <= uop_i.rd;
            res_q.value   <= alu_value;
            res_q.illegal <= uop_i.illegal;
        end
    end

    // Stored rd is owed to the register file until it retires
    assign ex_pend_o   = '{valid: res_valid_q, rd: res_q.rd};

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

/* source/int_decode.sv */
// Decode and operand gather for RV32I OP, OP-IMM, LUI and AUIPC
// No forwarding: a source that matches any pending rd holds in_ready_o low
// until the producer has been written back
// Register file reads are combinational, data must be valid the same cycle

module int_decode (
    input  logic                   g_clk,
    input  logic                   rst_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  pipe_pkg::instr_req_t   in_req_i,

    output rv_isa_pkg::reg_addr_t  rs1_addr_o,
    output rv_isa_pkg::reg_addr_t  rs2_addr_o,
    input  rv_isa_pkg::xword_t     rs1_data_i,
    input  rv_isa_pkg::xword_t     rs2_data_i,

    input  pipe_pkg::pend_dst_t    ex_pend_i,     // Held in execute
    input  pipe_pkg::pend_dst_t    res_pend_i,    // Held in result

    output logic                   uop_valid_o,
    input  logic                   uop_ready_i,
    output pipe_pkg::uop_t         uop_o
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [OPCODE_W-1:0] opcode_raw;
    logic [FUNCT3_W-1:0] f3;
    logic [FUNCT7_W-1:0] f7;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    xword_t              imm_i;
    xword_t              imm_u;
    logic                use_rs1;
    logic                use_rs2;
    logic                hazard;
    logic                accept;
    uop_t                uop_n;
    uop_t                uop_q;
    logic                uop_valid_q;
    pend_dst_t           own_pend;

    // funct3 to ALU op, sub only exists in the register form
    function automatic alu_op_e map_f3(input logic [FUNCT3_W-1:0] fn3,
                                       input logic alt, input logic reg_form);
        case (fn3)
            F3_ADD:  map_f3 = (alt && reg_form) ? SUB : ADD;
            F3_SLL:  map_f3 = SLL;
            F3_SLT:  map_f3 = SLT;
            F3_SLTU: map_f3 = SLTU;
            F3_XOR:  map_f3 = XOR;
            F3_SR:   map_f3 = alt ? SRA : SRL;
            F3_OR:   map_f3 = OR;
            F3_AND:  map_f3 = AND;
            default: map_f3 = AND;
        endcase
    endfunction

    function automatic logic src_hit(input reg_addr_t rs, input pend_dst_t p);
        return p.valid && (rs != '0) && (p.rd == rs);
    endfunction

    // Field extraction
    // ------------------------------------------------------------
    assign opcode_raw = in_req_i.instr[OPCODE_W-1:0];
    assign f3         = in_req_i.instr[F3_LSB +: FUNCT3_W];
    assign f7         = in_req_i.instr[F7_LSB +: FUNCT7_W];
    assign rs1        = in_req_i.instr[RS1_LSB +: REG_ADDR_W];
    assign rs2        = in_req_i.instr[RS2_LSB +: REG_ADDR_W];

    assign imm_i = {{(XLEN-12){in_req_i.instr[ILEN-1]}}, in_req_i.instr[ILEN-1:RS2_LSB]};
    assign imm_u = {in_req_i.instr[ILEN-1:F3_LSB], 12'b0};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // Operand selection and uop build
    always_comb begin
        uop_n.pc      = in_req_i.pc;
        uop_n.rd      = in_req_i.instr[RD_LSB +: REG_ADDR_W];
        uop_n.opr_a   = rs1_data_i;
        uop_n.opr_b   = imm_i;
        uop_n.alu_op  = ADD;
        uop_n.illegal = 1'b0;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;

        case (opcode_e'(opcode_raw))
            OP: begin
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                uop_n.opr_b  = rs2_data_i;
                uop_n.alu_op = map_f3(f3, f7 == F7_ALT, 1'b1);
                uop_n.illegal = !(f7 == F7_BASE ||
                                  (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR)));
            end
            OP_IMM: begin
                use_rs1      = 1'b1;
                uop_n.alu_op = map_f3(f3, f7 == F7_ALT, 1'b0);
                // Shift forms keep funct7 in the upper immediate bits
                if (f3 == F3_SLL) begin
                    uop_n.illegal = (f7 != F7_BASE);
                end else if (f3 == F3_SR) begin
                    uop_n.illegal = (f7 != F7_BASE) && (f7 != F7_ALT);
                end
            end
            LUI: begin
                uop_n.opr_a  = '0;
                uop_n.opr_b  = imm_u;
                uop_n.alu_op = OR;
            end
            AUIPC: begin
                uop_n.opr_a  = in_req_i.pc;
                uop_n.opr_b  = imm_u;
            end
            default: begin
                uop_n.opr_a   = '0;     // Result reads as zero
                uop_n.opr_b   = '0;
                uop_n.illegal = 1'b1;
            end
        endcase
    end

    // Hazards and handshake
    // ------------------------------------------------------------
    assign own_pend = '{valid: uop_valid_q, rd: uop_q.rd};

    assign hazard =
        (use_rs1 && (src_hit(rs1, own_pend) || src_hit(rs1, ex_pend_i) ||
                     src_hit(rs1, res_pend_i))) ||
        (use_rs2 && (src_hit(rs2, own_pend) || src_hit(rs2, ex_pend_i) ||
                     src_hit(rs2, res_pend_i)));

    assign in_ready_o = !hazard && (!uop_valid_q || uop_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            uop_valid_q <= 1'b0;
        end else if (accept) begin
            uop_valid_q <= 1'b1;
        end else if (uop_ready_i) begin
            uop_valid_q <= 1'b0;    // Drained into execute
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            uop_q <= uop_n;
        end
    end

    assign uop_valid_o = uop_valid_q;
    assign uop_o       = uop_q;

endmodule

/* source/pipe_pkg.sv */
// Records passed between the decode, execute and result stages
// Builds on the RV32I types, so it compiles after rv_isa_pkg

package pipe_pkg;

    // ALU operations, LUI reuses OR against a zero operand A
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // Top level input request
    typedef struct packed {
        rv_isa_pkg::xword_t           pc;
        logic [rv_isa_pkg::ILEN-1:0]  instr;
    } instr_req_t;

    // Decode to execute micro-op
    // ------------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::xword_t     pc;
        rv_isa_pkg::xword_t     opr_a;
        rv_isa_pkg::xword_t     opr_b;
        rv_isa_pkg::reg_addr_t  rd;
        alu_op_e                alu_op;
        logic                   illegal;    // Unknown encoding, no write-back
    } uop_t;

    // Execute to result record, also the top level output
    typedef struct packed {
        rv_isa_pkg::xword_t     pc;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::xword_t     value;
        logic                   illegal;
    } exec_res_t;

    // Destination still owed to the register file
    typedef struct packed {
        logic                   valid;
        rv_isa_pkg::reg_addr_t  rd;
    } pend_dst_t;

endpackage

/* source/rv_isa_pkg.sv */
// RV32I base encodings for the integer pipeline slice
// Only the OP, OP-IMM, LUI and AUIPC major opcodes are named here
// XLEN and the register count are fixed for RV32I

package rv_isa_pkg;

    // Widths
    // ------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;     // Uncompressed only
    localparam int NUM_REGS   = 32;     // x0 included
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Field positions in the 32-bit encoding
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;     // Also start of the I-type immediate
    localparam int F7_LSB     = 25;

    typedef logic [XLEN-1:0]       xword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes
    // ------------------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 of the arithmetic group, shared by OP and OP-IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // srl and sra
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

    // funct7 values, ALT selects sub and sra
    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

endpackage
